// ==== rn_map_pkg.sv ====
// Register rename widths, reserved itag value and shared record types
`default_nettype none

package rn_map_pkg;

   // ******************************
   // Field widths
   // ******************************
   localparam int AREG_W = 5;
   localparam int PREG_W = 6;
   localparam int ITAG_W = 7;

   typedef logic [AREG_W-1:0] areg_t;
   typedef logic [PREG_W-1:0] preg_t;
   typedef logic [ITAG_W-1:0] itag_t;

   // Producer already complete, nothing to wait on
   localparam itag_t ITAG_NONE = '1;

   // ******************************
   // Records
   // ******************************

   // Rename request, one destination per cycle
   typedef struct packed {
      areg_t dst_arc;
      itag_t itag;
   } rn_req_t;

   // Completion of one instruction
   typedef struct packed {
      areg_t arc;
      preg_t preg;
      itag_t itag;
   } comp_t;

   // Source lookup answer
   typedef struct packed {
      preg_t preg;
      itag_t itag;
   } src_map_t;

endpackage

`default_nettype wire

// ==== rn_free_list.sv ====
// Circular pool of free physical registers with pointers and free count
`timescale 1ns/1ns
`default_nettype none

module rn_free_list #(
   parameter int ARCH_DEPTH   = 16,
   parameter int RENAME_DEPTH = 40
) (
   input  wire logic              nclk,
   input  wire logic              reset,
   input  wire logic              pop,
   input  wire logic              flush_map,
   input  wire logic              rel_valid,
   input  rn_map_pkg::preg_t      rel_preg,
   output rn_map_pkg::preg_t      head_preg,
   output logic                   not_empty
);
   import rn_map_pkg::*;

   localparam int POOL_DEPTH = RENAME_DEPTH - ARCH_DEPTH;
   localparam int PTR_W      = (POOL_DEPTH > 1) ? $clog2(POOL_DEPTH) : 1;
   localparam int CNT_W      = $clog2(POOL_DEPTH + 1);

   preg_t [POOL_DEPTH-1:0] pool;
   logic  [PTR_W-1:0]      rd_ptr;
   logic  [PTR_W-1:0]      wr_ptr;
   logic  [CNT_W-1:0]      free_cnt;

   // Wrap at the pool depth, which need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(POOL_DEPTH - 1))
         return '0;
      return ptr + PTR_W'(1);
   endfunction

   // ******************************
   // Pool storage and pointers
   // ******************************
   always_ff @(posedge nclk)
   begin
      if (reset)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         for (int i = 0; i < POOL_DEPTH; i++)
            pool[i] <= preg_t'(ARCH_DEPTH + i);
      end
      else
      begin
         if (flush_map)
            rd_ptr <= wr_ptr;
         else if (pop)
            rd_ptr <= ptr_next(rd_ptr);
         // Released register goes to the tail
         if (rel_valid)
         begin
            pool[wr_ptr] <= rel_preg;
            wr_ptr       <= ptr_next(wr_ptr);
         end
      end
   end

   // Net change of one pop and one release per cycle
   always_ff @(posedge nclk)
   begin
      if (reset || flush_map)
         free_cnt <= CNT_W'(POOL_DEPTH);
      else
      begin
         case ({pop, rel_valid})
            2'b10:   free_cnt <= free_cnt - CNT_W'(1);
            2'b01:   free_cnt <= free_cnt + CNT_W'(1);
            default: free_cnt <= free_cnt;
         endcase
      end
   end

   assign head_preg = pool[rd_ptr];
   assign not_empty = (free_cnt != '0);

endmodule

`default_nettype wire

// ==== rn_comp_map.sv ====
// Completion map of committed mappings and the released-register stage
`timescale 1ns/1ns
`default_nettype none

module rn_comp_map #(
   parameter int ARCH_DEPTH = 16
) (
   input  wire logic                                nclk,
   input  wire logic                                reset,
   input  wire logic                                comp_valid,
   input  rn_map_pkg::comp_t                        comp,
   output rn_map_pkg::preg_t [ARCH_DEPTH-1:0]       comp_table,
   output logic                                     rel_valid,
   output rn_map_pkg::preg_t                        rel_preg
);
   import rn_map_pkg::*;

   preg_t old_preg;

   // Current occupant of the completing register
   always_comb
   begin
      old_preg = '0;
      for (int i = 0; i < ARCH_DEPTH; i++)
      begin
         if (comp.arc == areg_t'(i))
            old_preg = comp_table[i];
      end
   end

   always_ff @(posedge nclk)
   begin
      if (reset)
      begin
         rel_valid <= 1'b0;
         for (int i = 0; i < ARCH_DEPTH; i++)
            comp_table[i] <= preg_t'(i);
      end
      else
      begin
         rel_valid <= comp_valid;
         for (int i = 0; i < ARCH_DEPTH; i++)
         begin
            if (comp_valid && comp.arc == areg_t'(i))
               comp_table[i] <= comp.preg;
         end
      end
   end

   // Release stage payload
   always_ff @(posedge nclk)
   begin
      if (comp_valid)
         rel_preg <= old_preg;
   end

endmodule

`default_nettype wire

// ==== rn_spec_map.sv ====
// Speculative architected-to-physical map with itags, source lookup and flush restore
`timescale 1ns/1ns
`default_nettype none

module rn_spec_map #(
   parameter int ARCH_DEPTH = 16
) (
   input  wire logic                                nclk,
   input  wire logic                                reset,
   input  wire logic                                req_fire,
   input  rn_map_pkg::rn_req_t                      req,
   input  rn_map_pkg::preg_t                        alloc_preg,
   input  wire logic                                comp_valid,
   input  rn_map_pkg::itag_t                        comp_itag,
   input  wire logic                                flush_map,
   input  rn_map_pkg::preg_t [ARCH_DEPTH-1:0]       comp_table,
   input  rn_map_pkg::areg_t [2:0]                  src_arc,
   output rn_map_pkg::src_map_t [2:0]               src_map
);
   import rn_map_pkg::*;

   preg_t [ARCH_DEPTH-1:0] map_preg;
   itag_t [ARCH_DEPTH-1:0] map_itag;

   // ******************************
   // Map update
   // ******************************

   // Flush beats rename, rename beats the completion clear
   always_ff @(posedge nclk)
   begin
      if (reset)
      begin
         for (int i = 0; i < ARCH_DEPTH; i++)
         begin
            map_preg[i] <= preg_t'(i);
            map_itag[i] <= ITAG_NONE;
         end
      end
      else
      begin
         for (int i = 0; i < ARCH_DEPTH; i++)
         begin
            if (flush_map)
            begin
               map_preg[i] <= comp_table[i];
               map_itag[i] <= ITAG_NONE;
            end
            else if (req_fire && req.dst_arc == areg_t'(i))
            begin
               map_preg[i] <= alloc_preg;
               map_itag[i] <= req.itag;
            end
            else if (comp_valid && comp_itag == map_itag[i])
               map_itag[i] <= ITAG_NONE;
         end
      end
   end

   // ******************************
   // Source lookup
   // ******************************

   // Out of range register numbers read as zero
   always_comb
   begin
      for (int s = 0; s < 3; s++)
      begin
         src_map[s] = '0;
         for (int i = 0; i < ARCH_DEPTH; i++)
         begin
            if (src_arc[s] == areg_t'(i))
            begin
               src_map[s].preg = map_preg[i];
               src_map[s].itag = map_itag[i];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== rn_map_top.sv ====
// Rename map top level with free list, completion map, speculative map and handshake
`timescale 1ns/1ns
`default_nettype none

module rn_map_top #(
   parameter int ARCH_DEPTH   = 16,
   parameter int RENAME_DEPTH = 40
) (
   input  wire logic                   nclk,
   input  wire logic                   reset,
   // Rename request
   input  wire logic                   req_valid,
   input  rn_map_pkg::rn_req_t         req,
   output logic                        req_ready,
   output rn_map_pkg::preg_t           alloc_preg,
   // Source lookup
   input  rn_map_pkg::areg_t [2:0]     src_arc,
   output rn_map_pkg::src_map_t [2:0]  src_map,
   // Completion
   input  wire logic                   comp_valid,
   input  rn_map_pkg::comp_t           comp,
   input  wire logic                   flush_map
);
   import rn_map_pkg::*;

   logic                   req_fire;
   logic                   not_empty;
   logic                   rel_valid;
   preg_t                  rel_preg;
   preg_t                  head_preg;
   preg_t [ARCH_DEPTH-1:0] comp_table;

   // No rename while the pool is empty or the map is being restored
   assign req_ready  = not_empty & ~flush_map;
   assign req_fire   = req_valid & req_ready;
   assign alloc_preg = head_preg;

   // ******************************
   // Submodules
   // ******************************
   rn_free_list #(
      .ARCH_DEPTH   (ARCH_DEPTH),
      .RENAME_DEPTH (RENAME_DEPTH)
   ) rn_free_list_inst (
      .nclk      (nclk),
      .reset     (reset),
      .pop       (req_fire),
      .flush_map (flush_map),
      .rel_valid (rel_valid),
      .rel_preg  (rel_preg),
      .head_preg (head_preg),
      .not_empty (not_empty)
   );

   rn_comp_map #(
      .ARCH_DEPTH (ARCH_DEPTH)
   ) rn_comp_map_inst (
      .nclk       (nclk),
      .reset      (reset),
      .comp_valid (comp_valid),
      .comp       (comp),
      .comp_table (comp_table),
      .rel_valid  (rel_valid),
      .rel_preg   (rel_preg)
   );

   rn_spec_map #(
      .ARCH_DEPTH (ARCH_DEPTH)
   ) rn_spec_map_inst (
      .nclk       (nclk),
      .reset      (reset),
      .req_fire   (req_fire),
      .req        (req),
      .alloc_preg (head_preg),
      .comp_valid (comp_valid),
      .comp_itag  (comp.itag),
      .flush_map  (flush_map),
      .comp_table (comp_table),
      .src_arc    (src_arc),
      .src_map    (src_map)
   );

endmodule

`default_nettype wire

// ==== rn_free_list_chk.sv ====
// Free-list invariant assertions and their bind into the free list
`timescale 1ns/1ns
`default_nettype none

module rn_free_list_chk #(
   parameter int ARCH_DEPTH   = 16,
   parameter int RENAME_DEPTH = 40
) (
   input wire logic                                          nclk,
   input wire logic                                          reset,
   input wire logic                                          pop,
   input wire logic                                          not_empty,
   input wire logic                                          rel_valid,
   input wire logic                                          flush_map,
   input wire logic [$clog2(RENAME_DEPTH-ARCH_DEPTH+1)-1:0]  free_cnt
);
   localparam int POOL_DEPTH = RENAME_DEPTH - ARCH_DEPTH;

   int unsigned fail_cnt = 0;

   cnt_in_range: assert property (@(posedge nclk) disable iff (reset)
      free_cnt <= POOL_DEPTH)
   else
   begin
      $error("Free count is above the pool depth");
      fail_cnt++;
   end

   pop_when_free: assert property (@(posedge nclk) disable iff (reset) pop |-> not_empty)
   else
   begin
      $error("Register taken from an empty pool");
      fail_cnt++;
   end

   // Completions are kept away from the flush and the cycle before it
   no_rel_at_flush: assert property (@(posedge nclk) disable iff (reset)
      !(rel_valid && flush_map))
   else
   begin
      $error("Release arrived in a flush cycle");
      fail_cnt++;
   end

   no_rel_after_flush: assert property (@(posedge nclk) disable iff (reset)
      flush_map |=> !rel_valid)
   else
   begin
      $error("Release arrived in the cycle after a flush");
      fail_cnt++;
   end

endmodule

bind rn_free_list rn_free_list_chk #(
   .ARCH_DEPTH   (ARCH_DEPTH),
   .RENAME_DEPTH (RENAME_DEPTH)
) rn_free_list_chk_inst (
   .nclk      (nclk),
   .reset     (reset),
   .pop       (pop),
   .not_empty (not_empty),
   .rel_valid (rel_valid),
   .flush_map (flush_map),
   .free_cnt  (free_cnt)
);

`default_nettype wire

// ==== tb_rn_map.sv ====
// Rename map testbench with clock, reset, reference model, directed and random tests
`timescale 1ns/1ns
`default_nettype none

module tb_rn_map;
   import rn_map_pkg::*;

   localparam int ARCH_DEPTH   = 16;
   localparam int RENAME_DEPTH = 40;
   localparam int POOL_DEPTH   = RENAME_DEPTH - ARCH_DEPTH;
   localparam int MAX_CYCLES   = 2000;

   logic           nclk;
   logic           reset;
   logic           req_valid;
   rn_req_t        req;
   logic           req_ready;
   preg_t          alloc_preg;
   areg_t [2:0]    src_arc;
   src_map_t [2:0] src_map;
   logic           comp_valid;
   comp_t          comp;
   logic           flush_map;

   // ******************************
   // Reference model state
   // ******************************
   preg_t free_q[$];
   preg_t used_q[$];
   comp_t inflight[$];
   preg_t spec_preg[ARCH_DEPTH];
   itag_t spec_itag[ARCH_DEPTH];
   preg_t comp_preg[ARCH_DEPTH];
   logic  rel_pend;
   preg_t rel_pend_preg;
   logic  last_fire;
   int    errors;
   int    checks;
   int    tests;
   int    test_err0;
   int    cycle_cnt = 0;

   rn_map_top #(
      .ARCH_DEPTH   (ARCH_DEPTH),
      .RENAME_DEPTH (RENAME_DEPTH)
   ) rn_map_top_inst (
      .nclk       (nclk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .alloc_preg (alloc_preg),
      .src_arc    (src_arc),
      .src_map    (src_map),
      .comp_valid (comp_valid),
      .comp       (comp),
      .flush_map  (flush_map)
   );

   initial
      nclk = 1'b0;
   always #10 nclk = ~nclk;

   always @(posedge nclk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("Timeout: tests still running after %0d cycles", cycle_cnt);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input int unsigned exp,
                                  input int unsigned act);
      $display("MISMATCH time=%0t %s expected=0x%0h actual=0x%0h", $time, name, exp, act);
      errors++;
   endtask

   // Model of one clock edge, from the values driven before it
   task automatic update_model();
      preg_t head;
      last_fire = req_valid && free_q.size() != 0 && !flush_map;
      if (flush_map)
      begin
         foreach (spec_preg[i])
         begin
            spec_preg[i] = comp_preg[i];
            spec_itag[i] = ITAG_NONE;
         end
         // Taken entries in take order come back ahead of the free ones
         free_q = {used_q, free_q};
         used_q.delete();
         inflight.delete();
      end
      else
      begin
         if (comp_valid)
         begin
            foreach (spec_itag[i])
               if (spec_itag[i] == comp.itag)
                  spec_itag[i] = ITAG_NONE;
         end
         if (last_fire)
         begin
            head = free_q.pop_front();
            used_q.push_back(head);
            spec_preg[req.dst_arc] = head;
            spec_itag[req.dst_arc] = req.itag;
            inflight.push_back('{arc: req.dst_arc, preg: head, itag: req.itag});
         end
      end
      if (rel_pend)
      begin
         free_q.push_back(rel_pend_preg);
         void'(used_q.pop_front());
      end
      rel_pend = comp_valid;
      if (comp_valid)
      begin
         rel_pend_preg = comp_preg[comp.arc];
         comp_preg[comp.arc] = comp.preg;
      end
   endtask

   task automatic check_outputs();
      logic     exp_ready;
      src_map_t exp_map;
      exp_ready = free_q.size() != 0 && !flush_map;
      checks++;
      assert (req_ready === exp_ready)
         else report_mismatch("req_ready", exp_ready, req_ready);
      if (exp_ready)
      begin
         assert (alloc_preg === free_q[0])
            else report_mismatch("alloc_preg", free_q[0], alloc_preg);
      end
      for (int s = 0; s < 3; s++)
      begin
         exp_map = '{preg: spec_preg[src_arc[s]], itag: spec_itag[src_arc[s]]};
         assert (src_map[s] === exp_map)
            else report_mismatch($sformatf("src_map[%0d]", s), exp_map, src_map[s]);
      end
   endtask

   // A request not yet taken stays valid and unchanged
   task automatic drive_inputs(input logic rq, input logic cp, input logic fl);
      if (!(req_valid && !last_fire))
      begin
         req.dst_arc = areg_t'($urandom % ARCH_DEPTH);
         req.itag    = itag_t'($urandom % ITAG_NONE);
         req_valid   = rq;
      end
      src_arc[0] = req.dst_arc;
      src_arc[1] = areg_t'($urandom % ARCH_DEPTH);
      src_arc[2] = areg_t'($urandom % ARCH_DEPTH);
      comp_valid = cp && inflight.size() != 0;
      if (comp_valid)
      begin
         comp       = inflight.pop_front();
         src_arc[2] = comp.arc;
      end
      flush_map = fl;
   endtask

   task automatic run_cycle();
      @(posedge nclk);
      update_model();
      @(negedge nclk);
      check_outputs();
   endtask

   task automatic step(input logic rq, input logic cp);
      drive_inputs(rq, cp, 1'b0);
      run_cycle();
   endtask

   task automatic sweep_lookups();
      for (int g = 0; g < ARCH_DEPTH; g += 3)
      begin
         drive_inputs(1'b0, 1'b0, 1'b0);
         for (int s = 0; s < 3; s++)
            src_arc[s] = areg_t'((g + s) % ARCH_DEPTH);
         run_cycle();
      end
   endtask

   task automatic end_test(input string name);
      $display("Test %-14s finished with %0d errors", name, errors - test_err0);
      tests++;
      test_err0 = errors;
   endtask

   initial
   begin
      void'($urandom(32'h2b3a_f117));
      reset      = 1'b1;
      req_valid  = 1'b0;
      req        = '0;
      src_arc    = '0;
      comp_valid = 1'b0;
      comp       = '0;
      flush_map  = 1'b0;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      test_err0  = 0;
      last_fire  = 1'b0;
      rel_pend   = 1'b0;
      rel_pend_preg = '0;
      for (int i = 0; i < ARCH_DEPTH; i++)
      begin
         spec_preg[i] = preg_t'(i);
         spec_itag[i] = ITAG_NONE;
         comp_preg[i] = preg_t'(i);
      end
      for (int i = 0; i < POOL_DEPTH; i++)
         free_q.push_back(preg_t'(ARCH_DEPTH + i));
      repeat (2) @(posedge nclk);
      @(negedge nclk);
      reset = 1'b0;
      check_outputs();

      repeat (POOL_DEPTH + 4)
         step(1'b1, 1'b0);
      end_test("alloc_order");
      repeat (8)
         step(1'b0, 1'b1);
      step(1'b0, 1'b0);
      sweep_lookups();
      end_test("comp_clear");
      repeat (10)
         step(1'b1, 1'b0);
      end_test("recycle");
      step(1'b0, 1'b0);
      drive_inputs(1'b0, 1'b0, 1'b1);
      run_cycle();
      sweep_lookups();
      end_test("flush_restore");
      repeat (300)
         step(($urandom % 4) != 0, ($urandom % 3) == 0);
      end_test("random_mix");

      errors += rn_map_top_inst.rn_free_list_inst.rn_free_list_chk_inst.fail_cnt;
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
rn_map_pkg.sv
rn_free_list.sv
rn_comp_map.sv
rn_spec_map.sv
rn_map_top.sv
rn_free_list_chk.sv
tb_rn_map.sv

// ==== Bender.yml ====
package:
  name: rn_map

sources:
  - files:
      - rn_map_pkg.sv
      - rn_free_list.sv
      - rn_comp_map.sv
      - rn_spec_map.sv
      - rn_map_top.sv
  - target: test
    files:
      - rn_free_list_chk.sv
      - tb_rn_map.sv
